// ==== rtl/ddr_bridge_config.svh ====
`ifndef DDR_BRIDGE_CONFIG_SVH
`define DDR_BRIDGE_CONFIG_SVH

// ----------------------------------------------------------------------
// bridge widths and sizes
// ----------------------------------------------------------------------
`define NARROW_DW          32   // processor side data
`define WIDE_DW            128  // controller beat
`define LANES              4    // narrow words per beat
`define LANE_W             2    // lane index bits
`define ADDR_W             32   // processor address
`define MEM_ADDR_W         28   // controller address
`define ID_W               4
`define LEN_W              8
`define LANE_Q_DEPTH       2    // outstanding requests per direction
`define LOCK_SETTLE_CYCLES 128  // locked cycles before mem reset release

`endif

// ==== rtl/ddr_bridge_pkg.sv ====
`include "ddr_bridge_config.svh"

package ddr_bridge_pkg;

  // ----------------------------------------------------------------------
  // wide beat with flat and per lane views
  // ----------------------------------------------------------------------
  typedef union packed {
    logic [`WIDE_DW-1:0]               flat;  // controller view
    logic [`LANES-1:0][`NARROW_DW-1:0] lane;  // steering view
  } beat_u;

  // ----------------------------------------------------------------------
  // channel payloads
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic [`ID_W-1:0]   id;
    logic [`ADDR_W-1:0] addr;  // byte address
    logic [`LEN_W-1:0]  len;
  } aw_req_t;

  typedef aw_req_t ar_req_t;  // reads use the same layout

  typedef struct packed {
    logic [`ID_W-1:0]       id;
    logic [`MEM_ADDR_W-1:0] addr;  // beat aligned
    logic [`LEN_W-1:0]      len;
  } mem_aw_req_t;  // also carries wide read requests

  typedef struct packed {
    logic [`NARROW_DW-1:0]   data;
    logic [`NARROW_DW/8-1:0] strb;
    logic                    last;
  } w_beat_t;

  typedef struct packed {
    beat_u                 data;
    logic [`WIDE_DW/8-1:0] strb;  // one lane active
    logic                  last;
  } mem_w_beat_t;

  typedef struct packed {
    logic [`ID_W-1:0] id;
    logic [1:0]       resp;
  } b_rsp_t;

  typedef struct packed {
    logic [`ID_W-1:0]      id;
    logic [`NARROW_DW-1:0] data;
    logic [1:0]            resp;
    logic                  last;
  } r_beat_t;

  typedef struct packed {
    logic [`ID_W-1:0] id;
    beat_u            data;
    logic [1:0]       resp;
    logic             last;
  } mem_r_beat_t;

  typedef enum logic [1:0] {
    HOLD   = 2'd0,  // waiting for pll lock
    SETTLE = 2'd1,  // lock seen and counting
    MEM_UP = 2'd2,  // controller out of reset
    READY  = 2'd3   // user side running
  } rst_state_e;

endpackage

// ==== rtl/lock_settle_timer.sv ====
`timescale 1ns/1ns
`include "ddr_bridge_config.svh"

module lock_settle_timer (
  input  logic sys_clk,
  input  logic sys_rstn,
  input  logic count_en,  // locked and settling
  output logic settled
);

  localparam int LIMIT = `LOCK_SETTLE_CYCLES;
  localparam int CNT_W = $clog2(LIMIT + 1);

  logic [CNT_W-1:0] cnt;  // consecutive locked cycles

  always_ff @(posedge sys_clk or negedge sys_rstn) begin
    if (!sys_rstn) begin
      cnt <= '0;
    end else if (!count_en) begin
      cnt <= '0;  // any gap restarts the wait
    end else if (!settled) begin
      cnt <= cnt + 1'b1;  // holds at limit
    end
  end

  assign settled = (cnt == CNT_W'(LIMIT));

  // the count only advances on enabled cycles
  settle_after_count_a: assert property (@(posedge sys_clk) disable iff (!sys_rstn)
    $rose(settled) |-> $past(count_en));

endmodule

// ==== rtl/mem_reset_fsm.sv ====
`timescale 1ns/1ns

module mem_reset_fsm (
  input  logic sys_clk,
  input  logic sys_rstn,
  input  logic pll_locked,   // clock source stable
  input  logic ctrl_locked,  // controller clocking stable
  input  logic ctrl_srst,    // controller sync reset
  output logic mem_rstn,     // to memory controller
  output logic ui_rstn       // to user side logic
);

  import ddr_bridge_pkg::*;

  rst_state_e state;
  rst_state_e state_nxt;
  logic       count_en;
  logic       settled;

  assign count_en = (state == SETTLE) && pll_locked;

  lock_settle_timer settle_i (
    .sys_clk  (sys_clk),
    .sys_rstn (sys_rstn),
    .count_en (count_en),
    .settled  (settled)
  );

  // ----------------------------------------------------------------------
  // sequencing
  // ----------------------------------------------------------------------
  always_comb begin
    state_nxt = state;
    if (!pll_locked) begin
      state_nxt = HOLD;  // lock loss wins from any state
    end else begin
      case (state)
        HOLD:    state_nxt = SETTLE;
        SETTLE:  if (settled) state_nxt = MEM_UP;
        MEM_UP:  if (ctrl_locked && !ctrl_srst) state_nxt = READY;
        READY:   if (!ctrl_locked || ctrl_srst) state_nxt = MEM_UP;  // soft reset
        default: state_nxt = HOLD;
      endcase
    end
  end

  always_ff @(posedge sys_clk or negedge sys_rstn) begin
    if (!sys_rstn) begin
      state    <= HOLD;
      mem_rstn <= 1'b0;
      ui_rstn  <= 1'b0;
    end else begin
      state    <= state_nxt;
      mem_rstn <= (state_nxt == MEM_UP) || (state_nxt == READY);  // from next state
      ui_rstn  <= (state_nxt == READY);
    end
  end

  // user side never runs with the controller held in reset
  ui_needs_mem_a: assert property (@(posedge sys_clk) disable iff (!sys_rstn)
    ui_rstn |-> mem_rstn);

endmodule

// ==== rtl/lane_fifo.sv ====
`timescale 1ns/1ns
`include "ddr_bridge_config.svh"

module lane_fifo #(
  parameter int DEPTH = `LANE_Q_DEPTH  // power of two
) (
  input  logic               sys_clk,
  input  logic               sys_rstn,
  input  logic               clear,      // flush all entries
  input  logic               push,
  input  logic [`LANE_W-1:0] push_lane,
  input  logic               pop,
  output logic [`LANE_W-1:0] head_lane,  // oldest entry
  output logic               full,
  output logic               empty
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [`LANE_W-1:0] slot [DEPTH];  // lane storage
  logic [PTR_W-1:0]   rd_ptr;
  logic [PTR_W-1:0]   wr_ptr;
  logic [CNT_W-1:0]   count;         // occupancy

  assign wr_ptr    = rd_ptr + count[PTR_W-1:0];  // wraps with power of two depth
  assign head_lane = slot[rd_ptr];
  assign full      = (count == CNT_W'(DEPTH));
  assign empty     = (count == '0);

  always_ff @(posedge sys_clk) begin
    if (push) begin
      slot[wr_ptr] <= push_lane;
    end
  end

  always_ff @(posedge sys_clk or negedge sys_rstn) begin
    if (!sys_rstn) begin
      rd_ptr <= '0;
      count  <= '0;
    end else if (clear) begin
      rd_ptr <= '0;  // drop everything queued
      count  <= '0;
    end else begin
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // idle or push with pop
      endcase
    end
  end

  // callers gate their ready signals on full and empty
  no_push_full_a: assert property (@(posedge sys_clk) disable iff (!sys_rstn || clear)
    push |-> !full);
  no_pop_empty_a: assert property (@(posedge sys_clk) disable iff (!sys_rstn || clear)
    pop |-> !empty);

endmodule

// ==== rtl/write_lane_steer.sv ====
`timescale 1ns/1ns
`include "ddr_bridge_config.svh"

module write_lane_steer (
  input  logic                        sys_clk,
  input  logic                        sys_rstn,
  input  logic                        clear,        // user side in reset
  input  ddr_bridge_pkg::aw_req_t     aw,
  input  logic                        aw_valid,
  output logic                        aw_ready,
  input  ddr_bridge_pkg::w_beat_t     w,
  input  logic                        w_valid,
  output logic                        w_ready,
  output ddr_bridge_pkg::mem_aw_req_t mem_aw,
  output logic                        mem_aw_valid,
  input  logic                        mem_awready,
  output ddr_bridge_pkg::mem_w_beat_t mem_w,
  output logic                        mem_w_valid,
  input  logic                        mem_wready
);

  import ddr_bridge_pkg::*;

  localparam int OFS_W   = $clog2(`WIDE_DW / 8);  // byte offset bits within a beat
  localparam int NSTRB   = `NARROW_DW / 8;
  localparam int WSTRB_W = `WIDE_DW / 8;

  logic               q_full;
  logic               q_empty;
  logic [`LANE_W-1:0] head_lane;  // lane of oldest write awaiting data

  // ----------------------------------------------------------------------
  // address channel
  // ----------------------------------------------------------------------
  assign aw_ready     = mem_awready && !q_full;  // room for one more lane
  assign mem_aw_valid = aw_valid && !q_full;

  always_comb begin
    mem_aw.id   = aw.id;
    mem_aw.addr = {aw.addr[`MEM_ADDR_W-1:OFS_W], {OFS_W{1'b0}}};  // beat aligned
    mem_aw.len  = aw.len;
  end

  lane_fifo #(.DEPTH(`LANE_Q_DEPTH)) lane_q_i (
    .sys_clk   (sys_clk),
    .sys_rstn  (sys_rstn),
    .clear     (clear),
    .push      (aw_valid && aw_ready),
    .push_lane (aw.addr[OFS_W-1 -: `LANE_W]),  // word select bits
    .pop       (w_valid && w_ready),
    .head_lane (head_lane),
    .full      (q_full),
    .empty     (q_empty)
  );

  // ----------------------------------------------------------------------
  // data channel
  // ----------------------------------------------------------------------
  assign w_ready     = mem_wready && !q_empty;  // data waits for its address
  assign mem_w_valid = w_valid && !q_empty;

  always_comb begin
    mem_w.data.lane = {`LANES{w.data}};  // same word in every lane
    mem_w.strb      = WSTRB_W'(w.strb) << (NSTRB * head_lane);  // target lane only
    mem_w.last      = w.last;
  end

endmodule

// ==== rtl/read_lane_select.sv ====
`timescale 1ns/1ns
`include "ddr_bridge_config.svh"

module read_lane_select (
  input  logic                        sys_clk,
  input  logic                        sys_rstn,
  input  logic                        clear,        // user side in reset
  input  ddr_bridge_pkg::ar_req_t     ar,
  input  logic                        ar_valid,
  output logic                        ar_ready,
  output ddr_bridge_pkg::r_beat_t     r,
  output logic                        r_valid,
  input  logic                        r_ready,
  output ddr_bridge_pkg::mem_aw_req_t mem_ar,
  output logic                        mem_ar_valid,
  input  logic                        mem_arready,
  input  ddr_bridge_pkg::mem_r_beat_t mem_r,
  input  logic                        mem_r_valid,
  output logic                        mem_rready
);

  import ddr_bridge_pkg::*;

  localparam int OFS_W = $clog2(`WIDE_DW / 8);

  logic               q_full;
  logic               q_empty;
  logic [`LANE_W-1:0] head_lane;  // lane of oldest read in flight

  assign ar_ready     = mem_arready && !q_full;
  assign mem_ar_valid = ar_valid && !q_full;

  always_comb begin
    mem_ar.id   = ar.id;
    mem_ar.addr = {ar.addr[`MEM_ADDR_W-1:OFS_W], {OFS_W{1'b0}}};  // beat aligned
    mem_ar.len  = ar.len;
  end

  lane_fifo #(.DEPTH(`LANE_Q_DEPTH)) lane_q_i (
    .sys_clk   (sys_clk),
    .sys_rstn  (sys_rstn),
    .clear     (clear),
    .push      (ar_valid && ar_ready),
    .push_lane (ar.addr[OFS_W-1 -: `LANE_W]),
    .pop       (r_valid && r_ready),  // one beat per request
    .head_lane (head_lane),
    .full      (q_full),
    .empty     (q_empty)
  );

  always_comb begin
    r.id   = mem_r.id;
    r.data = mem_r.data.lane[head_lane];  // pick the requested word
    r.resp = mem_r.resp;
    r.last = mem_r.last;
  end

  assign r_valid    = mem_r_valid;
  assign mem_rready = r_ready;

  // controller returns data only for reads that were issued
  r_has_request_a: assert property (@(posedge sys_clk) disable iff (!sys_rstn || clear)
    (r_valid && r_ready) |-> !q_empty);

endmodule

// ==== rtl/master_mux.sv ====
`timescale 1ns/1ns

module master_mux (
  input  logic                    master_sel,  // high selects m1
  // master 0
  input  ddr_bridge_pkg::aw_req_t m0_aw,
  input  logic                    m0_aw_valid,
  output logic                    m0_aw_ready,
  input  ddr_bridge_pkg::w_beat_t m0_w,
  input  logic                    m0_w_valid,
  output logic                    m0_w_ready,
  output ddr_bridge_pkg::b_rsp_t  m0_b,
  output logic                    m0_b_valid,
  input  logic                    m0_b_ready,
  input  ddr_bridge_pkg::ar_req_t m0_ar,
  input  logic                    m0_ar_valid,
  output logic                    m0_ar_ready,
  output ddr_bridge_pkg::r_beat_t m0_r,
  output logic                    m0_r_valid,
  input  logic                    m0_r_ready,
  // master 1
  input  ddr_bridge_pkg::aw_req_t m1_aw,
  input  logic                    m1_aw_valid,
  output logic                    m1_aw_ready,
  input  ddr_bridge_pkg::w_beat_t m1_w,
  input  logic                    m1_w_valid,
  output logic                    m1_w_ready,
  output ddr_bridge_pkg::b_rsp_t  m1_b,
  output logic                    m1_b_valid,
  input  logic                    m1_b_ready,
  input  ddr_bridge_pkg::ar_req_t m1_ar,
  input  logic                    m1_ar_valid,
  output logic                    m1_ar_ready,
  output ddr_bridge_pkg::r_beat_t m1_r,
  output logic                    m1_r_valid,
  input  logic                    m1_r_ready,
  // shared downstream side
  output ddr_bridge_pkg::aw_req_t aw,
  output logic                    aw_valid,
  input  logic                    aw_ready,
  output ddr_bridge_pkg::w_beat_t w,
  output logic                    w_valid,
  input  logic                    w_ready,
  input  ddr_bridge_pkg::b_rsp_t  b,
  input  logic                    b_valid,
  output logic                    b_ready,
  output ddr_bridge_pkg::ar_req_t ar,
  output logic                    ar_valid,
  input  logic                    ar_ready,
  input  ddr_bridge_pkg::r_beat_t r,
  input  logic                    r_valid,
  output logic                    r_ready
);

  import ddr_bridge_pkg::*;

  // requests from the selected master
  assign aw       = master_sel ? m1_aw       : m0_aw;
  assign aw_valid = master_sel ? m1_aw_valid : m0_aw_valid;
  assign w        = master_sel ? m1_w        : m0_w;
  assign w_valid  = master_sel ? m1_w_valid  : m0_w_valid;
  assign ar       = master_sel ? m1_ar       : m0_ar;
  assign ar_valid = master_sel ? m1_ar_valid : m0_ar_valid;
  assign b_ready  = master_sel ? m1_b_ready  : m0_b_ready;
  assign r_ready  = master_sel ? m1_r_ready  : m0_r_ready;

  // idle master sees no handshakes
  assign m0_aw_ready = !master_sel && aw_ready;
  assign m1_aw_ready = master_sel && aw_ready;
  assign m0_w_ready  = !master_sel && w_ready;
  assign m1_w_ready  = master_sel && w_ready;
  assign m0_ar_ready = !master_sel && ar_ready;
  assign m1_ar_ready = master_sel && ar_ready;

  // responses zeroed toward the idle master
  assign m0_b       = master_sel ? '0 : b;
  assign m1_b       = master_sel ? b  : '0;
  assign m0_b_valid = !master_sel && b_valid;
  assign m1_b_valid = master_sel && b_valid;
  assign m0_r       = master_sel ? '0 : r;
  assign m1_r       = master_sel ? r  : '0;
  assign m0_r_valid = !master_sel && r_valid;
  assign m1_r_valid = master_sel && r_valid;

endmodule

// ==== rtl/ddr_bridge_top.sv ====
`timescale 1ns/1ns

module ddr_bridge_top (
  input  logic                        sys_clk,
  input  logic                        sys_rstn,
  input  logic                        pll_locked,
  input  logic                        ctrl_locked,
  input  logic                        ctrl_srst,
  input  logic                        master_sel,  // high hands the port to m1
  output logic                        mem_rstn,
  output logic                        ui_rstn,
  // processor side master
  input  ddr_bridge_pkg::aw_req_t     m0_aw,
  input  logic                        m0_aw_valid,
  output logic                        m0_aw_ready,
  input  ddr_bridge_pkg::w_beat_t     m0_w,
  input  logic                        m0_w_valid,
  output logic                        m0_w_ready,
  output ddr_bridge_pkg::b_rsp_t      m0_b,
  output logic                        m0_b_valid,
  input  logic                        m0_b_ready,
  input  ddr_bridge_pkg::ar_req_t     m0_ar,
  input  logic                        m0_ar_valid,
  output logic                        m0_ar_ready,
  output ddr_bridge_pkg::r_beat_t     m0_r,
  output logic                        m0_r_valid,
  input  logic                        m0_r_ready,
  // alternate master
  input  ddr_bridge_pkg::aw_req_t     m1_aw,
  input  logic                        m1_aw_valid,
  output logic                        m1_aw_ready,
  input  ddr_bridge_pkg::w_beat_t     m1_w,
  input  logic                        m1_w_valid,
  output logic                        m1_w_ready,
  output ddr_bridge_pkg::b_rsp_t      m1_b,
  output logic                        m1_b_valid,
  input  logic                        m1_b_ready,
  input  ddr_bridge_pkg::ar_req_t     m1_ar,
  input  logic                        m1_ar_valid,
  output logic                        m1_ar_ready,
  output ddr_bridge_pkg::r_beat_t     m1_r,
  output logic                        m1_r_valid,
  input  logic                        m1_r_ready,
  // controller port
  output ddr_bridge_pkg::mem_aw_req_t mem_aw,
  output logic                        mem_aw_valid,
  input  logic                        mem_awready,
  output ddr_bridge_pkg::mem_w_beat_t mem_w,
  output logic                        mem_w_valid,
  input  logic                        mem_wready,
  input  ddr_bridge_pkg::b_rsp_t      mem_b,
  input  logic                        mem_b_valid,
  output logic                        mem_bready,
  output ddr_bridge_pkg::mem_aw_req_t mem_ar,
  output logic                        mem_ar_valid,
  input  logic                        mem_arready,
  input  ddr_bridge_pkg::mem_r_beat_t mem_r,
  input  logic                        mem_r_valid,
  output logic                        mem_rready
);

  import ddr_bridge_pkg::*;

  // ----------------------------------------------------------------------
  // selected narrow master
  // ----------------------------------------------------------------------
  aw_req_t aw;
  logic    aw_valid;
  logic    aw_ready;
  w_beat_t w;
  logic    w_valid;
  logic    w_ready;
  ar_req_t ar;
  logic    ar_valid;
  logic    ar_ready;
  r_beat_t r;
  logic    r_valid;
  logic    r_ready;

  mem_reset_fsm reset_fsm_i (.*);

  // write response goes straight to the controller port
  master_mux mux_i (
    .*,
    .b       (mem_b),
    .b_valid (mem_b_valid),
    .b_ready (mem_bready)
  );

  // lane queues flush while the user side is in reset
  write_lane_steer wr_steer_i (
    .*,
    .clear (!ui_rstn)
  );

  read_lane_select rd_sel_i (
    .*,
    .clear (!ui_rstn)
  );

endmodule

// ==== tests/ddr_bridge_tb.sv ====
`timescale 1ns/1ns
`include "ddr_bridge_config.svh"

module ddr_bridge_tb;

  import ddr_bridge_pkg::*;

  localparam int CLK_PERIOD = 4;
  localparam int SETTLE     = `LOCK_SETTLE_CYCLES;
  localparam int HS_TMO     = 20;  // cycles allowed per handshake
  localparam int CH_AW      = 0;
  localparam int CH_W       = 1;
  localparam int CH_AR      = 2;
  localparam int CH_B       = 3;
  localparam int CH_R       = 4;
  // cycle budget of each test in run order
  localparam int BUDGET = 2 * (SETTLE + 40) + 4 * 60 + 4 * 60 + 80 + 120 + 120;

  logic sys_clk;
  logic sys_rstn;
  logic pll_locked;
  logic ctrl_locked;
  logic ctrl_srst;
  logic master_sel;
  logic mem_rstn;
  logic ui_rstn;

  aw_req_t m0_aw;
  aw_req_t m1_aw;
  w_beat_t m0_w;
  w_beat_t m1_w;
  b_rsp_t  m0_b;
  b_rsp_t  m1_b;
  ar_req_t m0_ar;
  ar_req_t m1_ar;
  r_beat_t m0_r;
  r_beat_t m1_r;
  logic    m0_aw_valid;
  logic    m0_aw_ready;
  logic    m0_w_valid;
  logic    m0_w_ready;
  logic    m0_b_valid;
  logic    m0_b_ready;
  logic    m0_ar_valid;
  logic    m0_ar_ready;
  logic    m0_r_valid;
  logic    m0_r_ready;
  logic    m1_aw_valid;
  logic    m1_aw_ready;
  logic    m1_w_valid;
  logic    m1_w_ready;
  logic    m1_b_valid;
  logic    m1_b_ready;
  logic    m1_ar_valid;
  logic    m1_ar_ready;
  logic    m1_r_valid;
  logic    m1_r_ready;

  mem_aw_req_t mem_aw;
  mem_aw_req_t mem_ar;
  mem_w_beat_t mem_w;
  b_rsp_t      mem_b;
  mem_r_beat_t mem_r;
  logic        mem_aw_valid;
  logic        mem_awready;
  logic        mem_w_valid;
  logic        mem_wready;
  logic        mem_b_valid;
  logic        mem_bready;
  logic        mem_ar_valid;
  logic        mem_arready;
  logic        mem_r_valid;
  logic        mem_rready;

  int          errors  = 0;
  int          checks  = 0;
  int          m0_leak = 0;  // m0 handshakes seen while m1 owns the port

  ddr_bridge_top dut_i (.*);

  initial begin
    sys_clk = 1'b0;
    forever #(CLK_PERIOD / 2) sys_clk = ~sys_clk;
  end

  initial begin
    #(40 * BUDGET * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, tests did not finish", 40 * BUDGET);
    $display("Result: FAILED");
    $finish;
  end

  always @(negedge sys_clk) begin
    if (master_sel && (m0_aw_ready || m0_w_ready || m0_r_valid)) begin
      m0_leak++;  // deselected master must stay idle
    end
  end

  // ----------------------------------------------------------------------
  // helpers
  // ----------------------------------------------------------------------
  task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t ns %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic report_error(input string what);
    errors++;
    $display("%0t ns: %s", $time, what);
  endtask

  task automatic next_cycle();
    @(posedge sys_clk);
    #1;  // drive point
  endtask

  function automatic logic handshake_seen(input int ch, input bit m);
    case (ch)
      CH_AW:   return m ? m1_aw_ready : m0_aw_ready;
      CH_W:    return m ? m1_w_ready : m0_w_ready;
      CH_AR:   return m ? m1_ar_ready : m0_ar_ready;
      CH_B:    return m ? m1_b_valid : m0_b_valid;
      default: return m ? m1_r_valid : m0_r_valid;
    endcase
  endfunction

  // returns at the sampling point of the transfer cycle
  task automatic wait_handshake(input int ch, input bit m, input string name);
    int n;
    n = 0;
    @(negedge sys_clk);
    while (!handshake_seen(ch, m) && n < HS_TMO) begin
      @(negedge sys_clk);
      n++;
    end
    if (!handshake_seen(ch, m)) begin
      report_error({"no handshake on channel ", name});
    end
  endtask

  task automatic wait_ui_level(input logic lvl, input int max_cycles, input string what);
    int n;
    n = 0;
    @(negedge sys_clk);
    while (ui_rstn !== lvl && n < max_cycles) begin
      @(negedge sys_clk);
      n++;
    end
    if (ui_rstn !== lvl) begin
      report_error(what);
    end
  endtask

  task automatic set_aw(input bit m, input aw_req_t a, input logic v);
    if (m) begin
      m1_aw       = a;
      m1_aw_valid = v;
    end else begin
      m0_aw       = a;
      m0_aw_valid = v;
    end
  endtask

  task automatic set_w(input bit m, input w_beat_t wb, input logic v);
    if (m) begin
      m1_w       = wb;
      m1_w_valid = v;
    end else begin
      m0_w       = wb;
      m0_w_valid = v;
    end
  endtask

  task automatic set_ar(input bit m, input ar_req_t a, input logic v);
    if (m) begin
      m1_ar       = a;
      m1_ar_valid = v;
    end else begin
      m0_ar       = a;
      m0_ar_valid = v;
    end
  endtask

  function automatic aw_req_t rand_req(input logic [1:0] lane);
    aw_req_t a;
    a.id        = 4'($urandom());
    a.addr      = $urandom();
    a.addr[3:0] = {lane, 2'b00};  // word select
    a.len       = '0;             // single beat
    return a;
  endfunction

  function automatic w_beat_t rand_beat();
    w_beat_t wb;
    wb.data = $urandom();
    wb.strb = 4'($urandom_range(15, 1));
    wb.last = 1'b1;
    return wb;
  endfunction

  // ----------------------------------------------------------------------
  // memory side responder and single transfers
  // ----------------------------------------------------------------------
  task automatic respond_b(input bit m, input b_rsp_t rsp);
    mem_b       = rsp;
    mem_b_valid = 1'b1;
    wait_handshake(CH_B, m, "b");
    check("b", 128'(m ? m1_b : m0_b), 128'(rsp));
    check("mem_bready", 128'(mem_bready), 128'(1));
    next_cycle();
    mem_b_valid = 1'b0;
  endtask

  task automatic write_once(input bit m, input aw_req_t a, input w_beat_t wb);
    logic [15:0] exp_strb;
    b_rsp_t      rsp;
    exp_strb                    = '0;
    exp_strb[4 * a.addr[3:2] +: 4] = wb.strb;  // chosen lane only
    set_aw(m, a, 1'b1);
    wait_handshake(CH_AW, m, "aw");
    check("mem_aw_valid", 128'(mem_aw_valid), 128'(1));
    check("mem_aw.addr", 128'(mem_aw.addr), 128'({a.addr[27:4], 4'h0}));
    check("mem_aw.id", 128'(mem_aw.id), 128'(a.id));
    next_cycle();
    set_aw(m, a, 1'b0);
    set_w(m, wb, 1'b1);
    wait_handshake(CH_W, m, "w");
    check("mem_w_valid", 128'(mem_w_valid), 128'(1));
    check("mem_w.data", mem_w.data.flat, {4{wb.data}});  // replicated word
    check("mem_w.strb", 128'(mem_w.strb), 128'(exp_strb));
    next_cycle();
    set_w(m, wb, 1'b0);
    rsp.id   = a.id;
    rsp.resp = 2'b00;
    respond_b(m, rsp);
  endtask

  task automatic read_once(input bit m, input ar_req_t a);
    logic [31:0] word [4];
    logic [31:0] rnd;
    mem_r_beat_t beat;
    r_beat_t     got;
    for (int i = 0; i < 4; i++) begin
      rnd     = $urandom();
      word[i] = {rnd[31:2], 2'(i)};  // low bits keep lanes distinct
    end
    set_ar(m, a, 1'b1);
    wait_handshake(CH_AR, m, "ar");
    check("mem_ar_valid", 128'(mem_ar_valid), 128'(1));
    check("mem_ar.addr", 128'(mem_ar.addr), 128'({a.addr[27:4], 4'h0}));
    next_cycle();
    set_ar(m, a, 1'b0);
    beat.id        = a.id;
    beat.data.flat = {word[3], word[2], word[1], word[0]};  // lane 0 lowest
    beat.resp      = 2'b00;
    beat.last      = 1'b1;
    mem_r          = beat;
    mem_r_valid    = 1'b1;
    wait_handshake(CH_R, m, "r");
    got = m ? m1_r : m0_r;
    check("r.data", 128'(got.data), 128'(word[a.addr[3:2]]));
    check("r.id", 128'(got.id), 128'(a.id));
    check("mem_rready", 128'(mem_rready), 128'(1));
    next_cycle();
    mem_r_valid = 1'b0;
  endtask

  // ----------------------------------------------------------------------
  // directed tests
  // ----------------------------------------------------------------------
  task automatic sequence_resets();
    int n;
    @(negedge sys_clk);
    check("mem_rstn", 128'(mem_rstn), 128'(0));
    check("ui_rstn", 128'(ui_rstn), 128'(0));
    check("mem_aw_valid", 128'(mem_aw_valid), 128'(0));
    check("m0_w_ready", 128'(m0_w_ready), 128'(0));
    next_cycle();
    pll_locked = 1'b1;
    n = 0;
    while (!mem_rstn && n <= SETTLE + 8) begin
      @(posedge sys_clk);
      n++;
      @(negedge sys_clk);
    end
    if (n < SETTLE || n > SETTLE + 4) begin
      report_error($sformatf("mem_rstn released %0d cycles after pll lock", n));
    end
    next_cycle();
    ctrl_locked = 1'b1;
    ctrl_srst   = 1'b1;  // controller still in soft reset
    repeat (4) next_cycle();
    @(negedge sys_clk);
    check("ui_rstn with ctrl_srst", 128'(ui_rstn), 128'(0));
    next_cycle();
    ctrl_srst = 1'b0;
    wait_ui_level(1'b1, 2, "ui_rstn did not rise after ctrl_srst dropped");
    next_cycle();
    pll_locked = 1'b0;  // lock loss
    next_cycle();
    @(negedge sys_clk);
    check("mem_rstn after lock loss", 128'(mem_rstn), 128'(0));
    check("ui_rstn after lock loss", 128'(ui_rstn), 128'(0));
    next_cycle();
    pll_locked = 1'b1;
    wait_ui_level(1'b1, SETTLE + 10, "ui_rstn did not return after relock");
    next_cycle();
  endtask

  task automatic steer_write_lanes();
    for (int l = 0; l < 4; l++) begin
      write_once(1'b0, rand_req(2'(l)), rand_beat());
    end
  endtask

  task automatic select_read_lanes();
    for (int l = 0; l < 4; l++) begin
      read_once(1'b0, rand_req(2'(l)));
    end
  endtask

  task automatic switch_masters();
    master_sel = 1'b1;
    set_aw(1'b0, rand_req(2'd1), 1'b1);  // m0 keeps requesting
    set_w(1'b0, rand_beat(), 1'b1);
    set_ar(1'b0, rand_req(2'd0), 1'b1);
    write_once(1'b1, rand_req(2'd2), rand_beat());
    read_once(1'b1, rand_req(2'd3));
    check("m0 handshakes while deselected", 128'(m0_leak), 128'(0));
    m0_aw_valid = 1'b0;
    m0_w_valid  = 1'b0;
    m0_ar_valid = 1'b0;
    master_sel  = 1'b0;
    next_cycle();
  endtask

  task automatic apply_back_pressure();
    aw_req_t     a [3];
    w_beat_t     wb;
    logic [15:0] exp_strb;
    for (int i = 0; i < 3; i++) begin
      a[i] = rand_req(2'(i + 1));
    end
    @(negedge sys_clk);
    check("m0_w_ready with no aw queued", 128'(m0_w_ready), 128'(0));
    next_cycle();
    for (int i = 0; i < 2; i++) begin
      set_aw(1'b0, a[i], 1'b1);
      wait_handshake(CH_AW, 1'b0, "aw");
      next_cycle();
    end
    set_aw(1'b0, a[2], 1'b1);  // third one finds the queue full
    repeat (3) begin
      @(negedge sys_clk);
      check("m0_aw_ready with full queue", 128'(m0_aw_ready), 128'(0));
      check("mem_aw_valid with full queue", 128'(mem_aw_valid), 128'(0));
      next_cycle();
    end
    set_aw(1'b0, a[2], 1'b0);
    mem_wready = 1'b0;
    wb = rand_beat();
    set_w(1'b0, wb, 1'b1);
    repeat (3) begin
      @(negedge sys_clk);
      check("m0_w_ready with mem_wready low", 128'(m0_w_ready), 128'(0));
      next_cycle();
    end
    mem_wready = 1'b1;
    for (int i = 0; i < 2; i++) begin  // drains in address order
      wait_handshake(CH_W, 1'b0, "w");
      exp_strb                       = '0;
      exp_strb[4 * a[i].addr[3:2] +: 4] = wb.strb;
      check("mem_w.strb", 128'(mem_w.strb), 128'(exp_strb));
      next_cycle();
    end
    set_w(1'b0, wb, 1'b0);
  endtask

  task automatic clear_on_soft_reset();
    for (int i = 0; i < 2; i++) begin
      set_aw(1'b0, rand_req(2'(i)), 1'b1);
      wait_handshake(CH_AW, 1'b0, "aw");
      next_cycle();
    end
    m0_aw_valid = 1'b0;
    ctrl_srst   = 1'b1;
    wait_ui_level(1'b0, 2, "ui_rstn did not drop on ctrl_srst");
    next_cycle();
    ctrl_srst = 1'b0;
    wait_ui_level(1'b1, 2, "ui_rstn did not return after ctrl_srst");
    repeat (3) begin
      check("m0_w_ready after soft reset", 128'(m0_w_ready), 128'(0));
      check("mem_rstn during soft reset", 128'(mem_rstn), 128'(1));
      @(negedge sys_clk);
    end
    next_cycle();
    write_once(1'b0, rand_req(2'd3), rand_beat());  // fresh lane after the flush
  endtask

  // ----------------------------------------------------------------------
  // run
  // ----------------------------------------------------------------------
  initial begin
    void'($urandom(32'h73d7));
    sys_rstn    = 1'b0;
    pll_locked  = 1'b0;
    ctrl_locked = 1'b0;
    ctrl_srst   = 1'b0;
    master_sel  = 1'b0;
    m0_aw       = '0;
    m0_aw_valid = 1'b0;
    m0_w        = '0;
    m0_w_valid  = 1'b0;
    m0_b_ready  = 1'b1;
    m0_ar       = '0;
    m0_ar_valid = 1'b0;
    m0_r_ready  = 1'b1;
    m1_aw       = '0;
    m1_aw_valid = 1'b0;
    m1_w        = '0;
    m1_w_valid  = 1'b0;
    m1_b_ready  = 1'b1;
    m1_ar       = '0;
    m1_ar_valid = 1'b0;
    m1_r_ready  = 1'b1;
    mem_awready = 1'b1;  // controller always accepting unless a test says otherwise
    mem_wready  = 1'b1;
    mem_arready = 1'b1;
    mem_b       = '0;
    mem_b_valid = 1'b0;
    mem_r       = '0;
    mem_r_valid = 1'b0;
    repeat (10) @(posedge sys_clk);
    #1;
    sys_rstn = 1'b1;

    sequence_resets();
    steer_write_lanes();
    select_read_lanes();
    switch_masters();
    apply_back_pressure();
    clear_on_soft_reset();

    repeat (2) next_cycle();
    $display("checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+rtl
rtl/ddr_bridge_pkg.sv
rtl/lock_settle_timer.sv
rtl/mem_reset_fsm.sv
rtl/lane_fifo.sv
rtl/write_lane_steer.sv
rtl/read_lane_select.sv
rtl/master_mux.sv
rtl/ddr_bridge_top.sv
tests/ddr_bridge_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= ddr_bridge_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Result: PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
